//--- hw/branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_id_config.svh"

module branch_resolve
	import rv_id_pkg::*;
(
	input  logic [`XLEN-1:0] pc_i,
	input  logic [`XLEN-1:0] imm_i,
	input  logic [`XLEN-1:0] op1_i,
	input  logic [`XLEN-1:0] op2_i,
	input  logic [2:0]       funct3_i,
	input  logic             is_branch_i,
	input  logic             is_jal_i,
	input  logic             is_jalr_i,
	output branch_t          branch_o
);

	logic eq;
	logic lt_s;
	logic lt_u;

	assign eq   = (op1_i == op2_i);
	assign lt_s = ($signed(op1_i) < $signed(op2_i));
	assign lt_u = (op1_i < op2_i);

	always_comb
	begin
		branch_o.taken  = 1'b0;
		branch_o.target = `ZERO_WORD;
		if (is_jal_i)
		begin
			branch_o.taken  = 1'b1;
			branch_o.target = pc_i + imm_i;
		end
		else if (is_jalr_i)
		begin
			branch_o.taken  = 1'b1;
			branch_o.target = op1_i + imm_i; // Register relative
		end
		else if (is_branch_i)
		begin
			branch_o.target = pc_i + imm_i;
			case (funct3_i)
				3'b000: branch_o.taken = eq;
				3'b001: branch_o.taken = !eq;
				3'b100: branch_o.taken = lt_s;
				3'b101: branch_o.taken = !lt_s;
				3'b110: branch_o.taken = lt_u;
				3'b111: branch_o.taken = !lt_u;
				default: branch_o.taken = 1'b0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_id_config.svh"

module inst_decoder
	import rv_id_pkg::*;
(
	input  inst_u     inst_i,
	output rf_req_t   rf_req_o,
	output dec_ctrl_t ctrl_o,
	output logic      is_branch_o,
	output logic      is_jal_o,
	output logic      is_jalr_o
);

	logic [6:0]       opcode;
	logic [2:0]       funct3;
	logic             f7b30;
	logic             is_reg;
	logic             valid;
	logic [`XLEN-1:0] imm_i_s;
	logic [`XLEN-1:0] imm_i_z;
	logic [`XLEN-1:0] imm_sh;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_b;
	logic [`XLEN-1:0] imm_u;
	logic [`XLEN-1:0] imm_j;

	assign opcode = inst_i.r_fmt.opcode;
	assign funct3 = inst_i.r_fmt.funct3;
	assign f7b30  = inst_i.r_fmt.funct7[5];
	assign is_reg = (opcode == OP_OP);

	assign imm_i_s = {{(`XLEN-12){inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
	assign imm_i_z = {{(`XLEN-12){1'b0}}, inst_i.i_fmt.imm};
	assign imm_sh  = {{(`XLEN-5){1'b0}}, inst_i.r_fmt.rs2}; // shamt sits in rs2
	assign imm_s   = {{(`XLEN-12){inst_i.s_fmt.imm_hi[6]}}, inst_i.s_fmt.imm_hi,
		inst_i.s_fmt.imm_lo};
	assign imm_b   = {{(`XLEN-12){inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_11,
		inst_i.b_fmt.imm_10_5, inst_i.b_fmt.imm_4_1, 1'b0};
	assign imm_u   = {inst_i.u_fmt.imm, 12'h000};
	assign imm_j   = {{(`XLEN-20){inst_i.j_fmt.imm_20}}, inst_i.j_fmt.imm_19_12,
		inst_i.j_fmt.imm_11, inst_i.j_fmt.imm_10_1, 1'b0};

	always_comb
	begin
		valid            = 1'b1;
		rf_req_o.r1_en   = 1'b0;
		rf_req_o.r2_en   = 1'b0;
		rf_req_o.r1_addr = inst_i.r_fmt.rs1;
		rf_req_o.r2_addr = inst_i.r_fmt.rs2;
		ctrl_o.aluop     = EX_NOP_OP;
		ctrl_o.alusel    = EX_RES_NOP;
		ctrl_o.w_en      = 1'b0;
		ctrl_o.w_addr    = `NOP_REG_ADDR;
		ctrl_o.imm       = `ZERO_WORD;
		case (opcode)
			OP_LUI:
			begin
				ctrl_o.aluop  = EX_OR_OP; // imm OR imm
				ctrl_o.alusel = EX_RES_LOGIC;
				ctrl_o.w_en   = 1'b1;
				ctrl_o.w_addr = inst_i.r_fmt.rd;
				ctrl_o.imm    = imm_u;
			end
			OP_AUIPC:
			begin
				ctrl_o.aluop  = EX_AUIPC_OP;
				ctrl_o.alusel = EX_RES_ARITH;
				ctrl_o.w_en   = 1'b1;
				ctrl_o.w_addr = inst_i.r_fmt.rd;
				ctrl_o.imm    = imm_u;
			end
			OP_JAL:
			begin
				ctrl_o.aluop  = EX_JAL_OP;
				ctrl_o.alusel = EX_RES_J_B;
				ctrl_o.w_en   = 1'b1;
				ctrl_o.w_addr = inst_i.r_fmt.rd;
				ctrl_o.imm    = imm_j;
			end
			OP_JALR:
			begin
				rf_req_o.r1_en = 1'b1;
				ctrl_o.aluop   = EX_JALR_OP;
				ctrl_o.alusel  = EX_RES_J_B;
				ctrl_o.w_en    = 1'b1;
				ctrl_o.w_addr  = inst_i.r_fmt.rd;
				ctrl_o.imm     = imm_i_s;
			end
			OP_BRANCH:
			begin
				rf_req_o.r1_en = 1'b1;
				rf_req_o.r2_en = 1'b1;
				ctrl_o.imm     = imm_b;
				case (funct3)
					3'b000: ctrl_o.aluop = EX_BEQ_OP;
					3'b001: ctrl_o.aluop = EX_BNE_OP;
					3'b100: ctrl_o.aluop = EX_BLT_OP;
					3'b101: ctrl_o.aluop = EX_BGE_OP;
					3'b110: ctrl_o.aluop = EX_BLTU_OP;
					3'b111: ctrl_o.aluop = EX_BGEU_OP;
					default: valid = 1'b0;
				endcase
			end
			OP_LOAD:
			begin
				rf_req_o.r1_en = 1'b1;
				ctrl_o.alusel  = EX_RES_LD_ST;
				ctrl_o.w_en    = 1'b1;
				ctrl_o.w_addr  = inst_i.r_fmt.rd;
				ctrl_o.imm     = imm_i_s;
				case (funct3)
					3'b000: ctrl_o.aluop = EX_LB_OP;
					3'b001: ctrl_o.aluop = EX_LH_OP;
					3'b010: ctrl_o.aluop = EX_LW_OP;
					3'b100: ctrl_o.aluop = EX_LBU_OP;
					3'b101: ctrl_o.aluop = EX_LHU_OP;
					default: valid = 1'b0;
				endcase
			end
			OP_STORE:
			begin
				rf_req_o.r1_en = 1'b1;
				rf_req_o.r2_en = 1'b1;
				ctrl_o.alusel  = EX_RES_LD_ST;
				ctrl_o.imm     = imm_s;
				case (funct3)
					3'b000: ctrl_o.aluop = EX_SB_OP;
					3'b001: ctrl_o.aluop = EX_SH_OP;
					3'b010: ctrl_o.aluop = EX_SW_OP;
					default: valid = 1'b0;
				endcase
			end
			OP_OPI, OP_OP:
			begin
				rf_req_o.r1_en = 1'b1;
				rf_req_o.r2_en = is_reg;
				ctrl_o.w_en    = 1'b1;
				ctrl_o.w_addr  = inst_i.r_fmt.rd;
				case (funct3)
					3'b000:
					begin
						ctrl_o.aluop  = (is_reg && f7b30) ? EX_SUB_OP : EX_ADD_OP;
						ctrl_o.alusel = EX_RES_ARITH;
						ctrl_o.imm    = imm_i_s;
					end
					3'b010, 3'b011:
					begin
						ctrl_o.aluop  = funct3[0] ? EX_SLTU_OP : EX_SLT_OP;
						ctrl_o.alusel = EX_RES_ARITH;
						ctrl_o.imm    = imm_i_s;
					end
					3'b001, 3'b101:
					begin
						ctrl_o.aluop  = !funct3[2] ? EX_SLL_OP : (f7b30 ? EX_SRA_OP : EX_SRL_OP);
						ctrl_o.alusel = EX_RES_SHIFT;
						ctrl_o.imm    = imm_sh;
					end
					default:
					begin
						// XOR, OR, AND
						ctrl_o.aluop  = !funct3[1] ? EX_XOR_OP : (funct3[0] ? EX_AND_OP : EX_OR_OP);
						ctrl_o.alusel = EX_RES_LOGIC;
						ctrl_o.imm    = imm_i_z;
					end
				endcase
				if (is_reg)
					ctrl_o.imm = `ZERO_WORD;
			end
			default: valid = 1'b0;
		endcase
		if (!valid)
		begin
			rf_req_o = '{r1_en: 1'b0, r2_en: 1'b0, r1_addr: `NOP_REG_ADDR,
				r2_addr: `NOP_REG_ADDR};
			ctrl_o   = '{aluop: EX_NOP_OP, alusel: EX_RES_NOP, w_en: 1'b0,
				w_addr: `NOP_REG_ADDR, imm: `ZERO_WORD};
		end
	end

	assign is_branch_o = valid && (opcode == OP_BRANCH);
	assign is_jal_o    = (opcode == OP_JAL);
	assign is_jalr_o   = (opcode == OP_JALR);

endmodule

`default_nettype wire

//--- hw/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_id_config.svh"

module operand_forward
	import rv_id_pkg::*;
(
	input  logic                   en_i,
	input  logic [`REG_ADDR_W-1:0] addr_i,
	input  logic [`XLEN-1:0]       rf_data_i,
	input  logic [`XLEN-1:0]       imm_i,
	input  fwd_t                   ex_fwd_i,
	input  fwd_t                   mem_fwd_i,
	output logic [`XLEN-1:0]       data_o,
	output logic                   hazard_o
);

	logic ex_hit;
	logic mem_hit;

	// x0 is not special here
	assign ex_hit  = (ex_fwd_i.w_addr == addr_i);
	assign mem_hit = (mem_fwd_i.w_addr == addr_i);

	always_comb
	begin
		data_o   = rf_data_i;
		hazard_o = 1'b0;
		if (!en_i)
			data_o = imm_i; // Unused source carries the immediate
		else if (ex_fwd_i.pre_ld && ex_hit)
			hazard_o = 1'b1; // Load result not back yet
		else if (ex_fwd_i.w_en && ex_hit)
			data_o = ex_fwd_i.w_data;
		else if (mem_fwd_i.w_en && mem_hit)
			data_o = mem_fwd_i.w_data;
	end

endmodule

`default_nettype wire

//--- hw/rv_id_config.svh
`ifndef RV_ID_CONFIG_SVH
`define RV_ID_CONFIG_SVH

// Data path and address width
`define XLEN 32

// Register file index width
`define REG_ADDR_W 5

// Default word for cleared operands and immediates
`define ZERO_WORD 32'h0000_0000

// x0, used when no register is addressed
`define NOP_REG_ADDR 5'd0

`endif

//--- hw/rv_id_pkg.sv
`default_nettype none
`include "rv_id_config.svh"

package rv_id_pkg;

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_JALR   = 7'b1100111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_OPI    = 7'b0010011,
		OP_OP     = 7'b0110011
	} opcode_e;

	typedef enum logic [7:0] {
		EX_NOP_OP   = 8'h00,
		EX_ADD_OP   = 8'h01,
		EX_SUB_OP   = 8'h02,
		EX_SLL_OP   = 8'h03,
		EX_SLT_OP   = 8'h04,
		EX_SLTU_OP  = 8'h05,
		EX_XOR_OP   = 8'h06,
		EX_SRL_OP   = 8'h07,
		EX_SRA_OP   = 8'h08,
		EX_OR_OP    = 8'h09,
		EX_AND_OP   = 8'h0a,
		EX_AUIPC_OP = 8'h10,
		EX_JAL_OP   = 8'h11,
		EX_JALR_OP  = 8'h12,
		EX_BEQ_OP   = 8'h20,
		EX_BNE_OP   = 8'h21,
		EX_BLT_OP   = 8'h22,
		EX_BGE_OP   = 8'h23,
		EX_BLTU_OP  = 8'h24,
		EX_BGEU_OP  = 8'h25,
		EX_LB_OP    = 8'h30,
		EX_LH_OP    = 8'h31,
		EX_LW_OP    = 8'h32,
		EX_LBU_OP   = 8'h33,
		EX_LHU_OP   = 8'h34,
		EX_SB_OP    = 8'h38,
		EX_SH_OP    = 8'h39,
		EX_SW_OP    = 8'h3a
	} alu_op_e;

	// Result class picked in EX
	typedef enum logic [2:0] {
		EX_RES_NOP   = 3'd0,
		EX_RES_LOGIC = 3'd1,
		EX_RES_SHIFT = 3'd2,
		EX_RES_ARITH = 3'd3,
		EX_RES_J_B   = 3'd4,
		EX_RES_LD_ST = 3'd5
	} alu_sel_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// One instruction word, six ways to read it
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	typedef struct packed {
		logic                   r1_en;
		logic                   r2_en;
		logic [`REG_ADDR_W-1:0] r1_addr;
		logic [`REG_ADDR_W-1:0] r2_addr;
	} rf_req_t;

	typedef struct packed {
		alu_op_e                aluop;
		alu_sel_e               alusel;
		logic                   w_en;
		logic [`REG_ADDR_W-1:0] w_addr;
		logic [`XLEN-1:0]       imm;
	} dec_ctrl_t;

	typedef struct packed {
		logic                   pre_ld; // Load in flight, data not ready yet
		logic                   w_en;
		logic [`REG_ADDR_W-1:0] w_addr;
		logic [`XLEN-1:0]       w_data;
	} fwd_t;

	typedef struct packed {
		logic             taken;
		logic [`XLEN-1:0] target;
	} branch_t;

	typedef struct packed {
		logic [`XLEN-1:0]       pc;
		alu_op_e                aluop;
		alu_sel_e               alusel;
		logic [`XLEN-1:0]       op1;
		logic [`XLEN-1:0]       op2;
		logic                   w_en;
		logic [`REG_ADDR_W-1:0] w_addr;
		logic [`XLEN-1:0]       imm;
	} id_ex_t;

endpackage

`default_nettype wire

//--- hw/rv_id_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_id_config.svh"

module rv_id_stage
	import rv_id_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic [`XLEN-1:0] pc_i,
	input  inst_u            inst_i,
	input  logic [`XLEN-1:0] r1_data_i,
	input  logic [`XLEN-1:0] r2_data_i,
	input  fwd_t             ex_fwd_i,
	input  fwd_t             mem_fwd_i,
	output rf_req_t          rf_req_o,
	output logic             stall_req_o,
	output branch_t          branch_o,
	output id_ex_t           id_ex_o
);

	localparam id_ex_t ID_EX_BUBBLE = '{pc: `ZERO_WORD, aluop: EX_NOP_OP,
		alusel: EX_RES_NOP, op1: `ZERO_WORD, op2: `ZERO_WORD, w_en: 1'b0,
		w_addr: `NOP_REG_ADDR, imm: `ZERO_WORD};

	dec_ctrl_t        ctrl;
	logic             is_branch;
	logic             is_jal;
	logic             is_jalr;
	logic [`XLEN-1:0] op1;
	logic [`XLEN-1:0] op2;
	logic             hazard1;
	logic             hazard2;

	inst_decoder i_inst_decoder (
		.inst_i      (inst_i),
		.rf_req_o    (rf_req_o),
		.ctrl_o      (ctrl),
		.is_branch_o (is_branch),
		.is_jal_o    (is_jal),
		.is_jalr_o   (is_jalr)
	);

	operand_forward i_fwd_r1 (
		.en_i      (rf_req_o.r1_en),
		.addr_i    (rf_req_o.r1_addr),
		.rf_data_i (r1_data_i),
		.imm_i     (ctrl.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.data_o    (op1),
		.hazard_o  (hazard1)
	);

	operand_forward i_fwd_r2 (
		.en_i      (rf_req_o.r2_en),
		.addr_i    (rf_req_o.r2_addr),
		.rf_data_i (r2_data_i),
		.imm_i     (ctrl.imm),
		.ex_fwd_i  (ex_fwd_i),
		.mem_fwd_i (mem_fwd_i),
		.data_o    (op2),
		.hazard_o  (hazard2)
	);

	assign stall_req_o = hazard1 | hazard2;

	// Compares use the forwarded operands
	branch_resolve i_branch_resolve (
		.pc_i        (pc_i),
		.imm_i       (ctrl.imm),
		.op1_i       (op1),
		.op2_i       (op2),
		.funct3_i    (inst_i.r_fmt.funct3),
		.is_branch_i (is_branch),
		.is_jal_i    (is_jal),
		.is_jalr_i   (is_jalr),
		.branch_o    (branch_o)
	);

	always_ff @(posedge clk)
	begin
		if (rst || stall_req_o)
			id_ex_o <= ID_EX_BUBBLE; // Bubble while upstream holds
		else
			id_ex_o <= '{pc: pc_i, aluop: ctrl.aluop, alusel: ctrl.alusel, op1: op1,
				op2: op2, w_en: ctrl.w_en, w_addr: ctrl.w_addr, imm: ctrl.imm};
	end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_rv_id_stage \
	-f rv_id_stage.f \
	-o sim_rv_id_stage

out=$(./obj_dir/sim_rv_id_stage)
echo "$out"

if grep -qx "test passed" <<< "$out"; then
	exit 0
else
	exit 1
fi

//--- rv_id_stage.f
+incdir+hw
hw/rv_id_pkg.sv
hw/inst_decoder.sv
hw/operand_forward.sv
hw/branch_resolve.sv
hw/rv_id_stage.sv
tb/rv_id_checker.sv
tb/tb_rv_id_stage.sv

//--- tb/rv_id_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_id_config.svh"

module rv_id_checker
	import rv_id_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input logic       stall_req_i,
	input logic [6:0] opcode_i,
	input logic       taken_i,
	input logic       w_en_i
);

	// A stalled cycle must leave a bubble behind
	stall_bubble: assert property (@(posedge clk) stall_req_i |=> !w_en_i)
		else $error("stall not followed by bubble");

	reset_bubble: assert property (@(posedge clk) rst |=> !w_en_i)
		else $error("write enable set after reset");

	jal_taken: assert property (@(posedge clk) (opcode_i == OP_JAL) |-> taken_i)
		else $error("JAL not taken");

endmodule

bind rv_id_stage rv_id_checker i_rv_id_checker (
	.clk         (clk),
	.rst         (rst),
	.stall_req_i (stall_req_o),
	.opcode_i    (inst_i.r_fmt.opcode),
	.taken_i     (branch_o.taken),
	.w_en_i      (id_ex_o.w_en)
);

`default_nettype wire

//--- tb/tb_rv_id_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_id_config.svh"

module tb_rv_id_stage
	import rv_id_pkg::*;
();

	localparam fwd_t NO_FWD = '0;
	localparam logic [31:0] RF1 = 32'h1111_1111;
	localparam logic [31:0] RF2 = 32'h2222_2222;

	logic             clk;
	logic             rst;
	logic [`XLEN-1:0] pc;
	logic [31:0]      inst;
	logic [`XLEN-1:0] r1_data;
	logic [`XLEN-1:0] r2_data;
	fwd_t             ex_fwd;
	fwd_t             mem_fwd;
	rf_req_t          rf_req;
	logic             stall_req;
	branch_t          branch;
	id_ex_t           id_ex;
	integer           seed = 59;
	integer           errors = 0;
	integer           tests_run = 0;
	integer           tests_failed = 0;

	rv_id_stage i_rv_id_stage (
		.clk         (clk),
		.rst         (rst),
		.pc_i        (pc),
		.inst_i      (inst),
		.r1_data_i   (r1_data),
		.r2_data_i   (r2_data),
		.ex_fwd_i    (ex_fwd),
		.mem_fwd_i   (mem_fwd),
		.rf_req_o    (rf_req),
		.stall_req_o (stall_req),
		.branch_o    (branch),
		.id_ex_o     (id_ex)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {f7, rs2, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic fwd_t make_fwd(input logic ld, input logic en, input logic [4:0] a,
		input logic [31:0] d);
		return '{pre_ld: ld, w_en: en, w_addr: a, w_data: d};
	endfunction

	// Branch outcome straight from the ISA rules
	function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
		input logic [31:0] b);
		case (f3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	task automatic report_error(input string msg);
		errors = errors + 1;
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
	endtask

	task automatic abort_run(input string msg);
		$display("Timeout: %s", msg);
		$display("test failed");
		$finish;
	endtask

	task automatic drive(input logic [31:0] p, input logic [31:0] word, input logic [31:0] d1,
		input logic [31:0] d2, input fwd_t exf, input fwd_t memf);
		@(posedge clk);
		pc      <= p;
		inst    <= word;
		r1_data <= d1;
		r2_data <= d2;
		ex_fwd  <= exf;
		mem_fwd <= memf;
		@(negedge clk); // Combinational outputs settled
	endtask

	task automatic step();
		@(posedge clk);
		@(negedge clk);
	endtask

	task automatic finish_test(input string name, input integer start_errors);
		tests_run = tests_run + 1;
		if (errors != start_errors)
		begin
			tests_failed = tests_failed + 1;
			$display("%s: FAIL, %0d errors", name, errors - start_errors);
		end
		else
			$display("%s: ok", name);
	endtask

	task automatic check_bubble(input string where);
		if (id_ex.w_en !== 1'b0 || id_ex.aluop !== EX_NOP_OP || id_ex.alusel !== EX_RES_NOP)
			report_error({where, ": id_ex is not a NOP"});
		if (id_ex.op1 !== 0 || id_ex.op2 !== 0 || id_ex.imm !== 0)
			report_error({where, ": bubble operands not zero"});
	endtask

	task automatic alu_case(input logic [31:0] word, input alu_op_e op, input alu_sel_e sel,
		input logic [31:0] imm, input logic two_src);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] p;
		a = $random(seed);
		b = $random(seed);
		p = $random(seed) & 32'hffff_fffc;
		drive(p, word, a, b, NO_FWD, NO_FWD);
		if (rf_req.r1_en !== 1'b1 || rf_req.r2_en !== two_src
			|| rf_req.r1_addr !== word[19:15])
			report_error($sformatf("read request wrong for %h", word));
		if (two_src && rf_req.r2_addr !== word[24:20])
			report_error($sformatf("rs2 address wrong for %h", word));
		step();
		if (id_ex.aluop !== op || id_ex.alusel !== sel)
			report_error($sformatf("ALU op/class wrong for %h", word));
		if (id_ex.imm !== imm)
			report_error($sformatf("imm %h, expected %h for %h", id_ex.imm, imm, word));
		if (id_ex.op1 !== a || id_ex.op2 !== (two_src ? b : imm))
			report_error($sformatf("operands wrong for %h", word));
		if (id_ex.w_en !== 1'b1 || id_ex.w_addr !== word[11:7] || id_ex.pc !== p)
			report_error($sformatf("write/pc wrong for %h", word));
	endtask

	task automatic alu_decode_test();
		integer e0;
		e0 = errors;
		alu_case(enc_r(7'h00, 2, 1, 3'd0, 3, OP_OP), EX_ADD_OP, EX_RES_ARITH, 0, 1);
		alu_case(enc_r(7'h20, 2, 1, 3'd0, 3, OP_OP), EX_SUB_OP, EX_RES_ARITH, 0, 1);
		alu_case(enc_r(7'h00, 2, 1, 3'd1, 3, OP_OP), EX_SLL_OP, EX_RES_SHIFT, 0, 1);
		alu_case(enc_r(7'h00, 2, 1, 3'd2, 3, OP_OP), EX_SLT_OP, EX_RES_ARITH, 0, 1);
		alu_case(enc_r(7'h00, 2, 1, 3'd3, 3, OP_OP), EX_SLTU_OP, EX_RES_ARITH, 0, 1);
		alu_case(enc_r(7'h00, 2, 1, 3'd4, 3, OP_OP), EX_XOR_OP, EX_RES_LOGIC, 0, 1);
		alu_case(enc_r(7'h00, 2, 1, 3'd5, 3, OP_OP), EX_SRL_OP, EX_RES_SHIFT, 0, 1);
		alu_case(enc_r(7'h20, 2, 1, 3'd5, 3, OP_OP), EX_SRA_OP, EX_RES_SHIFT, 0, 1);
		alu_case(enc_r(7'h00, 2, 1, 3'd6, 3, OP_OP), EX_OR_OP, EX_RES_LOGIC, 0, 1);
		alu_case(enc_r(7'h00, 2, 1, 3'd7, 3, OP_OP), EX_AND_OP, EX_RES_LOGIC, 0, 1);
		alu_case(enc_i(12'hffb, 1, 3'd0, 3, OP_OPI), EX_ADD_OP, EX_RES_ARITH, 32'hffff_fffb, 0);
		alu_case(enc_i(12'h800, 1, 3'd2, 4, OP_OPI), EX_SLT_OP, EX_RES_ARITH, 32'hffff_f800, 0);
		alu_case(enc_i(12'h7ff, 1, 3'd3, 5, OP_OPI), EX_SLTU_OP, EX_RES_ARITH, 32'h0000_07ff, 0);
		alu_case(enc_i(12'h8f0, 1, 3'd4, 6, OP_OPI), EX_XOR_OP, EX_RES_LOGIC, 32'h0000_08f0, 0);
		alu_case(enc_i(12'hfff, 1, 3'd6, 7, OP_OPI), EX_OR_OP, EX_RES_LOGIC, 32'h0000_0fff, 0);
		alu_case(enc_i(12'h955, 1, 3'd7, 8, OP_OPI), EX_AND_OP, EX_RES_LOGIC, 32'h0000_0955, 0);
		alu_case(enc_i(12'h007, 1, 3'd1, 9, OP_OPI), EX_SLL_OP, EX_RES_SHIFT, 7, 0);
		alu_case(enc_i(12'h01f, 1, 3'd5, 10, OP_OPI), EX_SRL_OP, EX_RES_SHIFT, 31, 0);
		// funct7 bit dropped
		alu_case(enc_i(12'h405, 1, 3'd5, 11, OP_OPI), EX_SRA_OP, EX_RES_SHIFT, 5, 0);
		finish_test("ALU decode", e0);
	endtask

	task automatic fmt_case(input logic [31:0] word, input logic r1e, input logic r2e,
		input logic wen, input alu_op_e op, input logic [31:0] imm);
		drive(32'h0000_1000, word, RF1, RF2, NO_FWD, NO_FWD);
		if (rf_req.r1_en !== r1e || rf_req.r2_en !== r2e)
			report_error($sformatf("read enables wrong for %h", word));
		if ((r1e && rf_req.r1_addr !== word[19:15])
			|| (r2e && rf_req.r2_addr !== word[24:20]))
			report_error($sformatf("read addresses wrong for %h", word));
		step();
		if (id_ex.w_en !== wen || id_ex.aluop !== op)
			report_error($sformatf("write/op wrong for %h", word));
		if (id_ex.imm !== imm)
			report_error($sformatf("imm %h, expected %h for %h", id_ex.imm, imm, word));
	endtask

	task automatic imm_format_test();
		integer e0;
		e0 = errors;
		fmt_case(enc_i(12'hff0, 1, 3'd2, 3, OP_LOAD), 1, 0, 1, EX_LW_OP, 32'hffff_fff0);
		fmt_case(enc_i(12'h07f, 1, 3'd4, 3, OP_LOAD), 1, 0, 1, EX_LBU_OP, 32'h0000_007f);
		fmt_case(enc_s(12'h9a4, 2, 1, 3'd2), 1, 1, 0, EX_SW_OP, 32'hffff_f9a4);
		fmt_case(enc_s(12'h123, 2, 1, 3'd0), 1, 1, 0, EX_SB_OP, 32'h0000_0123);
		fmt_case({20'hdead5, 5'd3, OP_LUI}, 0, 0, 1, EX_OR_OP, 32'hdead_5000);
		fmt_case({20'h12345, 5'd4, OP_AUIPC}, 0, 0, 1, EX_AUIPC_OP, 32'h1234_5000);
		finish_test("Immediate formats", e0);
	endtask

	task automatic fwd_case(input fwd_t exf, input fwd_t memf, input logic [31:0] e1,
		input logic [31:0] e2, input string name);
		drive(32'h0000_2000, enc_r(7'h00, 2, 1, 3'd0, 3, OP_OP), RF1, RF2, exf, memf);
		if (stall_req !== 1'b0)
			report_error({name, ": unexpected stall"});
		step();
		if (id_ex.op1 !== e1 || id_ex.op2 !== e2)
			report_error($sformatf("%s: op1 %h op2 %h", name, id_ex.op1, id_ex.op2));
	endtask

	task automatic forwarding_test();
		integer e0;
		logic [31:0] a;
		logic [31:0] b;
		e0 = errors;
		a = $random(seed);
		b = $random(seed);
		fwd_case(make_fwd(0, 1, 1, a), make_fwd(0, 1, 1, b), a, RF2, "ex over mem");
		fwd_case(make_fwd(0, 0, 1, a), make_fwd(0, 1, 1, b), b, RF2, "mem over rf");
		fwd_case(NO_FWD, make_fwd(0, 0, 2, b), RF1, RF2, "rf only");
		fwd_case(make_fwd(0, 1, 2, a), make_fwd(0, 1, 1, b), b, a, "split sources");
		fwd_case(make_fwd(0, 0, 2, a), make_fwd(0, 0, 1, b), RF1, RF2, "all disabled");
		finish_test("Forwarding priority", e0);
	endtask

	task automatic load_use_test();
		integer e0;
		integer n;
		logic [31:0] a;
		e0 = errors;
		a = $random(seed);
		drive(32'h0000_3000, enc_r(7'h00, 2, 1, 3'd0, 3, OP_OP), RF1, RF2,
			make_fwd(1, 1, 2, a), NO_FWD);
		if (stall_req !== 1'b1)
			report_error("no stall on load-use");
		step();
		check_bubble("load-use");
		// Load result arrives, stage retries the held instruction
		drive(32'h0000_3000, enc_r(7'h00, 2, 1, 3'd0, 3, OP_OP), RF1, RF2,
			make_fwd(0, 1, 2, a), NO_FWD);
		n = 0;
		while (stall_req && n < 5)
		begin
			step();
			n = n + 1;
		end
		if (stall_req)
			abort_run("stall request stayed high");
		step();
		if (id_ex.w_en !== 1'b1 || id_ex.op2 !== a)
			report_error("retried instruction not forwarded");
		drive(32'h0000_3004, enc_r(7'h00, 2, 1, 3'd0, 3, OP_OP), RF1, RF2,
			make_fwd(1, 1, 5, a), NO_FWD);
		if (stall_req !== 1'b0)
			report_error("stall on non-matching load");
		finish_test("Load-use stall", e0);
	endtask

	task automatic branch_test();
		integer e0;
		integer i;
		logic [2:0]  f3s [6];
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] p;
		logic [31:0] r;
		logic [12:0] imm;
		logic [20:0] jimm;
		e0 = errors;
		f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
		for (i = 0; i < 36; i = i + 1)
		begin
			f3 = f3s[i % 6];
			a = $random(seed);
			r = $random(seed);
			if ((i / 6) % 3 == 0)
				b = a;
			else if ((i / 6) % 3 == 1)
				b = {~a[31], r[30:0]}; // Opposite signs split signed from unsigned
			else
				b = r;
			p = $random(seed) & 32'hffff_fffc;
			r = $random(seed);
			imm = r[12:0] & 13'h1ffe;
			if ((i / 6) % 2)
				drive(p, enc_b(imm, 2, 1, f3), ~a, b, make_fwd(0, 1, 1, a), NO_FWD);
			else
				drive(p, enc_b(imm, 2, 1, f3), a, b, NO_FWD, NO_FWD);
			if (branch.taken !== branch_taken(f3, a, b))
				report_error($sformatf("branch f3 %0d a %h b %h", f3, a, b));
			if (branch.target !== p + {{19{imm[12]}}, imm})
				report_error($sformatf("branch target %h", branch.target));
		end
		r = $random(seed);
		jimm = r[20:0] & 21'h1ffffe;
		drive(p, enc_j(jimm, 1), a, b, NO_FWD, NO_FWD);
		if (branch.taken !== 1'b1 || branch.target !== p + {{11{jimm[20]}}, jimm})
			report_error("JAL target wrong");
		drive(p, enc_i(r[31:20], 1, 3'd0, 1, OP_JALR), ~a, b, NO_FWD, make_fwd(0, 1, 1, a));
		if (branch.taken !== 1'b1 || branch.target !== a + {{20{r[31]}}, r[31:20]})
			report_error("JALR target wrong");
		drive(p, enc_r(7'h00, 2, 1, 3'd0, 3, OP_OP), a, b, NO_FWD, NO_FWD);
		if (branch.taken !== 1'b0 || branch.target !== 0)
			report_error("non-jump taken");
		finish_test("Branches and jumps", e0);
	endtask

	task automatic illegal_case(input logic [31:0] word);
		drive(32'h0000_4000, word, RF1, RF2, NO_FWD, NO_FWD);
		if (rf_req.r1_en !== 1'b0 || rf_req.r2_en !== 1'b0 || branch.taken !== 1'b0)
			report_error($sformatf("illegal %h requests reads", word));
		step();
		check_bubble($sformatf("illegal %h", word));
	endtask

	task automatic reset_illegal_test();
		integer e0;
		integer n;
		e0 = errors;
		drive(32'h0000_4000, enc_r(7'h00, 2, 1, 3'd0, 3, OP_OP), RF1, RF2, NO_FWD, NO_FWD);
		@(posedge clk);
		rst <= 1'b1;
		n = 0;
		@(negedge clk);
		while (id_ex.w_en && n < 5)
		begin
			step();
			n = n + 1;
		end
		if (id_ex.w_en)
			abort_run("reset did not clear the ID/EX register");
		check_bubble("reset");
		@(posedge clk);
		rst <= 1'b0;
		illegal_case(32'hffff_ffff);
		illegal_case(enc_b(13'h0010, 2, 1, 3'd2));
		illegal_case(enc_i(12'h004, 1, 3'd3, 3, OP_LOAD));
		illegal_case(enc_s(12'h004, 2, 1, 3'd4));
		finish_test("Reset and illegal encodings", e0);
	endtask

	initial
	begin
		clk     = 1'b0;
		rst     = 1'b1;
		pc      = '0;
		inst    = '0;
		r1_data = '0;
		r2_data = '0;
		ex_fwd  = NO_FWD;
		mem_fwd = NO_FWD;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (id_ex.w_en !== 1'b0)
			report_error("w_en set after power-up reset");
		alu_decode_test();
		imm_format_test();
		forwarding_test();
		load_use_test();
		branch_test();
		reset_illegal_test();
		$display("Tests run %0d, tests failed %0d, check errors %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
